/* hdl/csr_pkg.sv */
// shared register addresses, field positions and data types for the csr block
package csr_pkg;

    typedef logic [13:0] csr_addr_t;
    typedef logic [31:0] csr_word_t;
    typedef logic [5:0]  ecode_t;
    typedef logic [8:0]  esubcode_t;
    typedef logic [1:0]  plv_t;

    // kept register addresses
    typedef enum csr_addr_t {
        CRMD   = 14'h000,
        PRMD   = 14'h001,
        ECTL   = 14'h004,
        ESTAT  = 14'h005,
        ERA    = 14'h006,
        EENTRY = 14'h00c,
        SAVE0  = 14'h030,
        SAVE1  = 14'h031,
        SAVE2  = 14'h032,
        SAVE3  = 14'h033,
        TID    = 14'h040,
        TCFG   = 14'h041,
        TVAL   = 14'h042,
        TICLR  = 14'h044
    } csr_addr_e;

    parameter int HW_INT_W = 8;

    // ==============================
    // field positions
    // ==============================
    parameter int CRMD_PLV_LO       = 0;
    parameter int CRMD_PLV_HI       = 1;
    parameter int CRMD_IE_BIT       = 2;
    parameter int CRMD_DA_BIT       = 3;
    parameter int CRMD_PG_BIT       = 4;
    parameter int CRMD_DATF_LO      = 5;
    parameter int CRMD_DATF_HI      = 6;
    parameter int CRMD_DATM_LO      = 7;
    parameter int CRMD_DATM_HI      = 8;

    parameter int PRMD_PPLV_LO      = 0;
    parameter int PRMD_PPLV_HI      = 1;
    parameter int PRMD_PIE_BIT      = 2;

    parameter int ESTAT_SWI_LO      = 0;
    parameter int ESTAT_SWI_HI      = 1;
    parameter int ESTAT_HWI_LO      = 2;
    parameter int ESTAT_HWI_HI      = 9;
    parameter int ESTAT_TI_BIT      = 11;
    parameter int ESTAT_ECODE_LO    = 16;
    parameter int ESTAT_ECODE_HI    = 21;
    parameter int ESTAT_ESUBCODE_LO = 22;
    parameter int ESTAT_ESUBCODE_HI = 30;

    parameter int ECTL_LIE_LO       = 0;
    parameter int ECTL_LIE_HI       = 12;

    parameter int TCFG_EN_BIT       = 0;
    parameter int TCFG_PERIODIC_BIT = 1;
    parameter int TCFG_INITVAL_LO   = 2;

    parameter int TICLR_CLR_BIT     = 0;

    parameter int EENTRY_BASE_LO    = 6;
    parameter int EENTRY_BASE_HI    = 31;

endpackage

/* hdl/csr_ifs.sv */
// write/read address bus and trap event bus shared by the csr register blocks
`timescale 1ns/10ps

interface csr_write_if;
    logic                 wr_en;
    csr_pkg::csr_addr_t   wr_addr;
    csr_pkg::csr_word_t   wr_data;
    csr_pkg::csr_addr_t   rd_addr;

    modport src  (output wr_en, wr_addr, wr_data, rd_addr);
    modport sink (input  wr_en, wr_addr, wr_data, rd_addr);
endinterface

interface csr_trap_if;
    logic                 excp_flush;
    logic                 ertn_flush;
    csr_pkg::csr_word_t   era_in;
    csr_pkg::ecode_t      ecode_in;
    csr_pkg::esubcode_t   esubcode_in;

    modport src  (output excp_flush, ertn_flush, era_in, ecode_in, esubcode_in);
    modport sink (input  excp_flush, ertn_flush, era_in, ecode_in, esubcode_in);
endinterface

/* hdl/csr_mode_regs.sv */
// crmd, prmd, era and eentry registers with exception entry and return handling
`timescale 1ns/10ps

module csr_mode_regs (
    input  logic                clk,
    input  logic                reset,
    csr_write_if.sink           wr,
    csr_trap_if.sink            trap,
    output csr_pkg::csr_word_t  crmd,
    output csr_pkg::csr_word_t  prmd,
    output csr_pkg::csr_word_t  era,
    output csr_pkg::csr_word_t  eentry,
    output logic                ie,
    output csr_pkg::plv_t       plv
);

    logic [csr_pkg::CRMD_DATM_HI:0]   crmd_q;
    logic [csr_pkg::PRMD_PIE_BIT:0]   prmd_q;
    csr_pkg::csr_word_t               era_q;
    logic [csr_pkg::EENTRY_BASE_HI:csr_pkg::EENTRY_BASE_LO] eentry_q;

    logic crmd_wen;
    logic prmd_wen;
    logic era_wen;
    logic eentry_wen;

    assign crmd_wen   = wr.wr_en && (wr.wr_addr == csr_pkg::CRMD);
    assign prmd_wen   = wr.wr_en && (wr.wr_addr == csr_pkg::PRMD);
    assign era_wen    = wr.wr_en && (wr.wr_addr == csr_pkg::ERA);
    assign eentry_wen = wr.wr_en && (wr.wr_addr == csr_pkg::EENTRY);

    // ==============================
    // crmd
    // ==============================
    always_ff @(posedge clk) begin
        if (reset) begin
            crmd_q <= '0;
            crmd_q[csr_pkg::CRMD_DA_BIT] <= 1'b1;
        end else if (trap.excp_flush) begin
            // enter kernel with interrupts off
            crmd_q[csr_pkg::CRMD_PLV_HI:csr_pkg::CRMD_PLV_LO] <= '0;
            crmd_q[csr_pkg::CRMD_IE_BIT] <= 1'b0;
        end else if (trap.ertn_flush) begin
            crmd_q[csr_pkg::CRMD_PLV_HI:csr_pkg::CRMD_PLV_LO] <=
                prmd_q[csr_pkg::PRMD_PPLV_HI:csr_pkg::PRMD_PPLV_LO];
            crmd_q[csr_pkg::CRMD_IE_BIT] <= prmd_q[csr_pkg::PRMD_PIE_BIT];
        end else if (crmd_wen) begin
            crmd_q[csr_pkg::CRMD_PLV_HI:csr_pkg::CRMD_PLV_LO] <=
                wr.wr_data[csr_pkg::CRMD_PLV_HI:csr_pkg::CRMD_PLV_LO];
            crmd_q[csr_pkg::CRMD_IE_BIT] <= wr.wr_data[csr_pkg::CRMD_IE_BIT];
            crmd_q[csr_pkg::CRMD_DA_BIT] <= wr.wr_data[csr_pkg::CRMD_DA_BIT];
            crmd_q[csr_pkg::CRMD_PG_BIT] <= wr.wr_data[csr_pkg::CRMD_PG_BIT];
            crmd_q[csr_pkg::CRMD_DATF_HI:csr_pkg::CRMD_DATF_LO] <=
                wr.wr_data[csr_pkg::CRMD_DATF_HI:csr_pkg::CRMD_DATF_LO];
            crmd_q[csr_pkg::CRMD_DATM_HI:csr_pkg::CRMD_DATM_LO] <=
                wr.wr_data[csr_pkg::CRMD_DATM_HI:csr_pkg::CRMD_DATM_LO];
        end
    end

    // prmd saves the mode on entry
    always_ff @(posedge clk) begin
        if (reset) begin
            prmd_q <= '0;
        end else if (trap.excp_flush) begin
            prmd_q[csr_pkg::PRMD_PPLV_HI:csr_pkg::PRMD_PPLV_LO] <=
                crmd_q[csr_pkg::CRMD_PLV_HI:csr_pkg::CRMD_PLV_LO];
            prmd_q[csr_pkg::PRMD_PIE_BIT] <= crmd_q[csr_pkg::CRMD_IE_BIT];
        end else if (prmd_wen) begin
            prmd_q <= wr.wr_data[csr_pkg::PRMD_PIE_BIT:0];
        end
    end

    always_ff @(posedge clk) begin
        if (trap.excp_flush) begin
            era_q <= trap.era_in;
        end else if (era_wen) begin
            era_q <= wr.wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (eentry_wen) begin
            eentry_q <= wr.wr_data[csr_pkg::EENTRY_BASE_HI:csr_pkg::EENTRY_BASE_LO];
        end
    end

    assign crmd   = csr_pkg::csr_word_t'(crmd_q);
    assign prmd   = csr_pkg::csr_word_t'(prmd_q);
    assign era    = era_q;
    assign eentry = {eentry_q, {csr_pkg::EENTRY_BASE_LO{1'b0}}};
    assign ie     = crmd_q[csr_pkg::CRMD_IE_BIT];
    assign plv    = crmd_q[csr_pkg::CRMD_PLV_HI:csr_pkg::CRMD_PLV_LO];

    flush_excl_a: assert property (@(posedge clk) disable iff (reset)
        !(trap.excp_flush && trap.ertn_flush))
        else $error("excp_flush and ertn_flush overlap");

endmodule

/* hdl/csr_exc_status.sv */
// estat and ectl registers, timer interrupt bit and the pending interrupt output
`timescale 1ns/10ps

module csr_exc_status (
    input  logic                          clk,
    input  logic                          reset,
    csr_write_if.sink                     wr,
    csr_trap_if.sink                      trap,
    input  logic [csr_pkg::HW_INT_W-1:0]  interrupt,
    input  logic                          ie,
    input  logic                          timer_fire,
    input  logic                          ticlr_clear,
    output csr_pkg::csr_word_t            estat,
    output csr_pkg::csr_word_t            ectl,
    output logic                          has_int
);

    logic [csr_pkg::ESTAT_SWI_HI:csr_pkg::ESTAT_SWI_LO] swi_q;
    logic [csr_pkg::HW_INT_W-1:0]                       hwi_q;
    logic                                               ti_q;
    csr_pkg::ecode_t                                    ecode_q;
    csr_pkg::esubcode_t                                 esubcode_q;
    logic [csr_pkg::ECTL_LIE_HI:csr_pkg::ECTL_LIE_LO]   ectl_q;

    logic estat_wen;
    logic ectl_wen;

    assign estat_wen = wr.wr_en && (wr.wr_addr == csr_pkg::ESTAT);
    assign ectl_wen  = wr.wr_en && (wr.wr_addr == csr_pkg::ECTL);

    // ==============================
    // estat
    // ==============================
    always_ff @(posedge clk) begin
        if (reset) begin
            swi_q      <= '0;
            hwi_q      <= '0;
            ti_q       <= 1'b0;
            ecode_q    <= '0;
            esubcode_q <= '0;
        end else begin
            // hw lines sampled every cycle
            hwi_q <= interrupt;
            if (ticlr_clear) begin
                ti_q <= 1'b0;
            end else if (timer_fire) begin
                ti_q <= 1'b1;
            end
            if (trap.excp_flush) begin
                ecode_q    <= trap.ecode_in;
                esubcode_q <= trap.esubcode_in;
            end else if (estat_wen) begin
                swi_q <= wr.wr_data[csr_pkg::ESTAT_SWI_HI:csr_pkg::ESTAT_SWI_LO];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ectl_q <= '0;
        end else if (ectl_wen) begin
            ectl_q <= wr.wr_data[csr_pkg::ECTL_LIE_HI:csr_pkg::ECTL_LIE_LO];
        end
    end

    always_comb begin
        estat = '0;
        estat[csr_pkg::ESTAT_SWI_HI:csr_pkg::ESTAT_SWI_LO]           = swi_q;
        estat[csr_pkg::ESTAT_HWI_HI:csr_pkg::ESTAT_HWI_LO]           = hwi_q;
        estat[csr_pkg::ESTAT_TI_BIT]                                 = ti_q;
        estat[csr_pkg::ESTAT_ECODE_HI:csr_pkg::ESTAT_ECODE_LO]       = ecode_q;
        estat[csr_pkg::ESTAT_ESUBCODE_HI:csr_pkg::ESTAT_ESUBCODE_LO] = esubcode_q;
    end

    assign ectl = csr_pkg::csr_word_t'(ectl_q);

    // pending bits masked by lie, then gated by the global enable
    assign has_int = ie &&
        (|(ectl_q & estat[csr_pkg::ECTL_LIE_HI:csr_pkg::ECTL_LIE_LO]));

    flush_excl_a: assert property (@(posedge clk) disable iff (reset)
        !(trap.excp_flush && trap.ertn_flush))
        else $error("excp_flush and ertn_flush overlap");

endmodule

/* hdl/csr_timer.sv */
// countdown timer with one-shot or periodic reload, timer id and 64-bit counter
`timescale 1ns/10ps

module csr_timer #(
    parameter int TIMER_W = 32
) (
    input  logic                clk,
    input  logic                reset,
    csr_write_if.sink           wr,
    output csr_pkg::csr_word_t  tcfg,
    output csr_pkg::csr_word_t  tval,
    output csr_pkg::csr_word_t  tid,
    output logic                timer_fire,
    output logic                ticlr_clear,
    output logic [63:0]         timer_64
);

    logic                                           tcfg_en_q;
    logic                                           tcfg_periodic_q;
    logic [TIMER_W-1:csr_pkg::TCFG_INITVAL_LO]      tcfg_initval_q;
    logic                                           timer_en;
    logic [TIMER_W-1:0]                             tval_q;
    logic [TIMER_W-1:0]                             reload_val;
    csr_pkg::csr_word_t                             tid_q;
    logic [63:0]                                    count_q;

    logic tcfg_wen;
    logic tid_wen;

    assign tcfg_wen    = wr.wr_en && (wr.wr_addr == csr_pkg::TCFG);
    assign tid_wen     = wr.wr_en && (wr.wr_addr == csr_pkg::TID);
    assign ticlr_clear = wr.wr_en && (wr.wr_addr == csr_pkg::TICLR) &&
                         wr.wr_data[csr_pkg::TICLR_CLR_BIT];

    assign reload_val = {tcfg_initval_q, {csr_pkg::TCFG_INITVAL_LO{1'b0}}};
    assign timer_fire = timer_en && (tval_q == '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            tcfg_en_q       <= 1'b0;
            tcfg_periodic_q <= 1'b0;
            tcfg_initval_q  <= '0;
        end else if (tcfg_wen) begin
            tcfg_en_q       <= wr.wr_data[csr_pkg::TCFG_EN_BIT];
            tcfg_periodic_q <= wr.wr_data[csr_pkg::TCFG_PERIODIC_BIT];
            tcfg_initval_q  <= wr.wr_data[TIMER_W-1:csr_pkg::TCFG_INITVAL_LO];
        end
    end

    // ==============================
    // countdown
    // ==============================
    always_ff @(posedge clk) begin
        if (reset) begin
            timer_en <= 1'b0;
            tval_q   <= '0;
        end else if (tcfg_wen) begin
            timer_en <= wr.wr_data[csr_pkg::TCFG_EN_BIT];
            tval_q   <= {wr.wr_data[TIMER_W-1:csr_pkg::TCFG_INITVAL_LO],
                         {csr_pkg::TCFG_INITVAL_LO{1'b0}}};
        end else if (timer_fire) begin
            // one-shot parks at all ones and stops
            timer_en <= tcfg_periodic_q;
            tval_q   <= tcfg_periodic_q ? reload_val : '1;
        end else if (timer_en) begin
            tval_q <= tval_q - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            tid_q <= '0;
        end else if (tid_wen) begin
            tid_q <= wr.wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            count_q <= '0;
        end else begin
            count_q <= count_q + 64'd1;
        end
    end

    assign tcfg     = csr_pkg::csr_word_t'({tcfg_initval_q, tcfg_periodic_q, tcfg_en_q});
    assign tval     = csr_pkg::csr_word_t'(tval_q);
    assign tid      = tid_q;
    assign timer_64 = count_q;

    tval_hold_a: assert property (@(posedge clk) disable iff (reset)
        (!tcfg_en_q && !tcfg_wen) |=> (tval_q == $past(tval_q)))
        else $error("tval moved while timer disabled");

endmodule

/* hdl/csr_scratch_read.sv */
// save0 to save3 scratch registers and the read-data selector over all registers
`timescale 1ns/10ps

module csr_scratch_read (
    input  logic                clk,
    csr_write_if.sink           wr,
    input  csr_pkg::csr_word_t  crmd,
    input  csr_pkg::csr_word_t  prmd,
    input  csr_pkg::csr_word_t  era,
    input  csr_pkg::csr_word_t  eentry,
    input  csr_pkg::csr_word_t  estat,
    input  csr_pkg::csr_word_t  ectl,
    input  csr_pkg::csr_word_t  tcfg,
    input  csr_pkg::csr_word_t  tval,
    input  csr_pkg::csr_word_t  tid,
    output csr_pkg::csr_word_t  rd_data
);

    csr_pkg::csr_word_t save_q [4];

    always_ff @(posedge clk) begin
        if (wr.wr_en) begin
            case (wr.wr_addr)
                csr_pkg::SAVE0: save_q[0] <= wr.wr_data;
                csr_pkg::SAVE1: save_q[1] <= wr.wr_data;
                csr_pkg::SAVE2: save_q[2] <= wr.wr_data;
                csr_pkg::SAVE3: save_q[3] <= wr.wr_data;
                default: ;
            endcase
        end
    end

    // ==============================
    // read mux
    // ==============================
    always_comb begin
        case (wr.rd_addr)
            csr_pkg::CRMD:   rd_data = crmd;
            csr_pkg::PRMD:   rd_data = prmd;
            csr_pkg::ECTL:   rd_data = ectl;
            csr_pkg::ESTAT:  rd_data = estat;
            csr_pkg::ERA:    rd_data = era;
            csr_pkg::EENTRY: rd_data = eentry;
            csr_pkg::SAVE0:  rd_data = save_q[0];
            csr_pkg::SAVE1:  rd_data = save_q[1];
            csr_pkg::SAVE2:  rd_data = save_q[2];
            csr_pkg::SAVE3:  rd_data = save_q[3];
            csr_pkg::TID:    rd_data = tid;
            csr_pkg::TCFG:   rd_data = tcfg;
            csr_pkg::TVAL:   rd_data = tval;
            // ticlr is write-only, reads as zero like unknown addresses
            default:         rd_data = '0;
        endcase
    end

endmodule

/* hdl/csr_top.sv */
// csr block top level, ties the register blocks to the core-facing ports
`timescale 1ns/10ps

module csr_top #(
    parameter int TIMER_W = 32
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          wr_en,
    input  csr_pkg::csr_addr_t            wr_addr,
    input  csr_pkg::csr_addr_t            rd_addr,
    input  csr_pkg::csr_word_t            wr_data,
    output csr_pkg::csr_word_t            rd_data,
    input  logic [csr_pkg::HW_INT_W-1:0]  interrupt,
    input  logic                          excp_flush,
    input  logic                          ertn_flush,
    input  csr_pkg::csr_word_t            era_in,
    input  csr_pkg::ecode_t               ecode_in,
    input  csr_pkg::esubcode_t            esubcode_in,
    output logic                          has_int,
    output csr_pkg::plv_t                 plv_out,
    output csr_pkg::csr_word_t            eentry_out,
    output csr_pkg::csr_word_t            era_out,
    output logic [63:0]                   timer_64_out,
    output csr_pkg::csr_word_t            tid_out
);

    csr_write_if wr_bus ();
    csr_trap_if  trap_bus ();

    csr_pkg::csr_word_t crmd;
    csr_pkg::csr_word_t prmd;
    csr_pkg::csr_word_t estat;
    csr_pkg::csr_word_t ectl;
    csr_pkg::csr_word_t tcfg;
    csr_pkg::csr_word_t tval;
    logic               crmd_ie;
    logic               timer_fire;
    logic               ticlr_clear;

    assign wr_bus.wr_en   = wr_en;
    assign wr_bus.wr_addr = wr_addr;
    assign wr_bus.wr_data = wr_data;
    assign wr_bus.rd_addr = rd_addr;

    assign trap_bus.excp_flush  = excp_flush;
    assign trap_bus.ertn_flush  = ertn_flush;
    assign trap_bus.era_in      = era_in;
    assign trap_bus.ecode_in    = ecode_in;
    assign trap_bus.esubcode_in = esubcode_in;

    csr_mode_regs mode0 (
        .clk(clk), .reset(reset), .wr(wr_bus), .trap(trap_bus),
        .crmd(crmd), .prmd(prmd), .era(era_out), .eentry(eentry_out),
        .ie(crmd_ie), .plv(plv_out)
    );

    csr_exc_status exc0 (
        .clk(clk), .reset(reset), .wr(wr_bus), .trap(trap_bus),
        .interrupt(interrupt), .ie(crmd_ie),
        .timer_fire(timer_fire), .ticlr_clear(ticlr_clear),
        .estat(estat), .ectl(ectl), .has_int(has_int)
    );

    csr_timer #(.TIMER_W(TIMER_W)) timer0 (
        .clk(clk), .reset(reset), .wr(wr_bus),
        .tcfg(tcfg), .tval(tval), .tid(tid_out),
        .timer_fire(timer_fire), .ticlr_clear(ticlr_clear),
        .timer_64(timer_64_out)
    );

    csr_scratch_read read0 (
        .clk(clk), .wr(wr_bus),
        .crmd(crmd), .prmd(prmd), .era(era_out), .eentry(eentry_out),
        .estat(estat), .ectl(ectl), .tcfg(tcfg), .tval(tval), .tid(tid_out),
        .rd_data(rd_data)
    );

endmodule

/* dv/csr_tb.sv */
// testbench for the csr block, replays the operations in dv/csr_testdata.txt against csr_top
`timescale 1ns/10ps

module csr_tb;

    localparam int WAIT_LIMIT = 2000;

    logic                          clk;
    logic                          reset;
    logic                          wr_en;
    csr_pkg::csr_addr_t            wr_addr;
    csr_pkg::csr_addr_t            rd_addr;
    csr_pkg::csr_word_t            wr_data;
    csr_pkg::csr_word_t            rd_data;
    logic [csr_pkg::HW_INT_W-1:0]  interrupt;
    logic                          excp_flush;
    logic                          ertn_flush;
    csr_pkg::csr_word_t            era_in;
    csr_pkg::ecode_t               ecode_in;
    csr_pkg::esubcode_t            esubcode_in;
    logic                          has_int;
    csr_pkg::plv_t                 plv_out;
    csr_pkg::csr_word_t            eentry_out;
    csr_pkg::csr_word_t            era_out;
    logic [63:0]                   timer_64_out;
    csr_pkg::csr_word_t            tid_out;

    string       cur_test;
    int          test_count;
    int          test_errors;
    int          error_count;
    logic [31:0] save_exp [4];
    int unsigned rand_seed;

    csr_top #(.TIMER_W(32)) dut0 (
        .clk(clk), .reset(reset), .wr_en(wr_en), .wr_addr(wr_addr), .rd_addr(rd_addr),
        .wr_data(wr_data), .rd_data(rd_data), .interrupt(interrupt),
        .excp_flush(excp_flush), .ertn_flush(ertn_flush), .era_in(era_in),
        .ecode_in(ecode_in), .esubcode_in(esubcode_in), .has_int(has_int),
        .plv_out(plv_out), .eentry_out(eentry_out), .era_out(era_out),
        .timer_64_out(timer_64_out), .tid_out(tid_out)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // overall run limit
    initial begin
        repeat (200000) @(posedge clk);
        $display("run stopped, simulation exceeded its cycle limit");
        $display("RESULT: FAIL");
        $finish;
    end

    task automatic report_mismatch(input logic [31:0] exp, input logic [31:0] act);
        $display("Fail %s: expected %h, actual %h", cur_test, exp, act);
        test_errors++;
        error_count++;
    endtask

    task automatic close_test();
        if (cur_test != "") begin
            $display("test %s finished with %0d errors", cur_test, test_errors);
            test_count++;
        end
        test_errors = 0;
    endtask

    task automatic write_reg(input csr_pkg::csr_addr_t addr, input logic [31:0] data);
        @(posedge clk);
        wr_en   <= 1'b1;
        wr_addr <= addr;
        wr_data <= data;
        @(posedge clk);
        wr_en   <= 1'b0;
    endtask

    // rd_data is combinational, sampled mid-cycle
    task automatic read_reg(input csr_pkg::csr_addr_t addr, output logic [31:0] data);
        @(posedge clk);
        rd_addr <= addr;
        @(negedge clk);
        data = rd_data;
    endtask

    task automatic sample_port(input logic [1:0] sel, output logic [31:0] data);
        @(posedge clk);
        @(negedge clk);
        case (sel)
            2'd0:    data = {31'b0, has_int};
            2'd1:    data = {30'b0, plv_out};
            2'd2:    data = era_out;
            default: data = eentry_out;
        endcase
    endtask

    // code packs esubcode above ecode
    task automatic raise_exception(input logic [14:0] code, input logic [31:0] era);
        @(posedge clk);
        excp_flush  <= 1'b1;
        ecode_in    <= code[5:0];
        esubcode_in <= code[14:6];
        era_in      <= era;
        @(posedge clk);
        excp_flush  <= 1'b0;
    endtask

    task automatic return_exception();
        @(posedge clk);
        ertn_flush <= 1'b1;
        @(posedge clk);
        ertn_flush <= 1'b0;
    endtask

    // also reports how far the free-running counter moved while waiting
    task automatic wait_for_int(input logic level, output logic reached,
                                output int unsigned waited, output logic [63:0] count_delta);
        int          n;
        logic [63:0] first_count;
        n = 0;
        reached = 1'b0;
        first_count = '0;
        while (!reached && n < WAIT_LIMIT) begin
            @(negedge clk);
            if (n == 0) begin
                first_count = timer_64_out;
            end
            if (has_int === level) begin
                reached = 1'b1;
            end
            n++;
        end
        waited = n;
        count_delta = timer_64_out - first_count;
    endtask

    initial begin
        int          fd;
        int          fields;
        string       line;
        string       name;
        string       op;
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] value;
        logic        reached;
        int unsigned waited;
        logic [63:0] count_delta;

        rand_seed   = $urandom(32'h7131);
        reset       = 1'b1;
        wr_en       = 1'b0;
        wr_addr     = '0;
        rd_addr     = '0;
        wr_data     = '0;
        interrupt   = '0;
        excp_flush  = 1'b0;
        ertn_flush  = 1'b0;
        era_in      = '0;
        ecode_in    = '0;
        esubcode_in = '0;
        cur_test    = "";
        test_count  = 0;
        test_errors = 0;
        error_count = 0;

        repeat (2) @(posedge clk);
        reset <= 1'b0;

        fd = $fopen("dv/csr_testdata.txt", "r");
        if (fd == 0) begin
            $display("could not open the data file dv/csr_testdata.txt");
            error_count++;
        end
        while (fd != 0 && !$feof(fd)) begin
            line = "";
            fields = $fgets(line, fd);
            fields = $sscanf(line, "%s %s %h %h", name, op, addr, data);
            if (line.len() > 0 && line.substr(0, 0) != "#" && fields == 4) begin
                if (name != cur_test) begin
                    close_test();
                    cur_test = name;
                end
                if (op == "write") begin
                    write_reg(addr[13:0], data);
                end else if (op == "read") begin
                    read_reg(addr[13:0], value);
                    if (value !== data) report_mismatch(data, value);
                    // registers with a core-facing copy
                    if (addr[13:0] == csr_pkg::EENTRY && eentry_out !== data) begin
                        report_mismatch(data, eentry_out);
                    end
                    if (addr[13:0] == csr_pkg::TID && tid_out !== data) begin
                        report_mismatch(data, tid_out);
                    end
                end else if (op == "rwrite") begin
                    save_exp[addr[1:0]] = $urandom;
                    write_reg(addr[13:0], save_exp[addr[1:0]]);
                end else if (op == "rread") begin
                    read_reg(addr[13:0], value);
                    if (value !== save_exp[addr[1:0]]) report_mismatch(save_exp[addr[1:0]], value);
                end else if (op == "excp") begin
                    raise_exception(addr[14:0], data);
                end else if (op == "ertn") begin
                    return_exception();
                end else if (op == "irq") begin
                    @(posedge clk);
                    interrupt <= data[csr_pkg::HW_INT_W-1:0];
                end else if (op == "wait_int") begin
                    wait_for_int(data[0], reached, waited, count_delta);
                    if (!reached) begin
                        $display("%s: has_int did not reach %0d within %0d cycles",
                                 cur_test, data[0], WAIT_LIMIT);
                        test_errors++;
                        error_count++;
                    end
                    if (count_delta !== 64'(waited - 1)) begin
                        $display("Fail %s: counter step expected %0d, actual %0d",
                                 cur_test, waited - 1, count_delta);
                        test_errors++;
                        error_count++;
                    end
                end else if (op == "port") begin
                    sample_port(addr[1:0], value);
                    if (value !== data) report_mismatch(data, value);
                end else begin
                    $display("%s: unknown operation %s in the data file", cur_test, op);
                    test_errors++;
                    error_count++;
                end
            end
        end
        close_test();
        if (fd != 0) begin
            $fclose(fd);
        end

        $display("%0d tests run, %0d errors", test_count, error_count);
        if (error_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* src.f */
hdl/csr_pkg.sv
hdl/csr_ifs.sv
hdl/csr_mode_regs.sv
hdl/csr_exc_status.sv
hdl/csr_timer.sv
hdl/csr_scratch_read.sv
hdl/csr_top.sv
dv/csr_tb.sv

/* Bender.yml */
package:
  name: csr_block

sources:
  - hdl/csr_pkg.sv
  - hdl/csr_ifs.sv
  - hdl/csr_mode_regs.sv
  - hdl/csr_exc_status.sv
  - hdl/csr_timer.sv
  - hdl/csr_scratch_read.sv
  - hdl/csr_top.sv
  - target: test
    files:
      - dv/csr_tb.sv

/* dv/csr_testdata.txt */
# columns: test name, operation, address or select (hex), data or expected value (hex)
# excp packs {esubcode, ecode} in the address column; port selects 0 has_int 1 plv 2 era 3 eentry
reset_values read 000 00000008
reset_values read 005 00000000
reset_values read 004 00000000
reset_values read 041 00000000
reset_values read 040 00000000
scratch rwrite 030 00000000
scratch rwrite 031 00000000
scratch rwrite 032 00000000
scratch rwrite 033 00000000
scratch rread 030 00000000
scratch rread 031 00000000
scratch rread 032 00000000
scratch rread 033 00000000
scratch write 00c ffffffff
scratch read 00c ffffffc0
excp_entry write 000 0000000f
excp_entry read 000 0000000f
excp_entry excp 0c5 1c001234
excp_entry read 001 00000007
excp_entry read 000 00000008
excp_entry read 006 1c001234
excp_entry read 005 00c50000
excp_entry port 002 1c001234
excp_return ertn 000 00000000
excp_return read 000 0000000f
excp_return port 001 00000003
timer_int write 004 00000800
timer_int write 000 0000000c
timer_int write 041 00000011
timer_int read 041 00000011
timer_int wait_int 000 00000001
timer_int read 005 00c50800
timer_int read 042 ffffffff
timer_int write 044 00000001
timer_int port 000 00000000
timer_int read 005 00c50000
hw_mask write 004 00000000
hw_mask irq 000 00000004
hw_mask port 000 00000000
hw_mask read 005 00c50010
hw_mask write 004 00000010
hw_mask port 000 00000001
hw_mask write 000 00000008
hw_mask port 000 00000000
hw_mask irq 000 00000000
